//--- hdl/mipsPkg.sv
`default_nettype none

package mipsPkg;

    //////////////////////////////////////////////////////////////////////
    // field widths and vector types
    //////////////////////////////////////////////////////////////////////

    // data path and instruction word
    typedef logic [31:0] wordT;
    // register index, 32 registers
    typedef logic [4:0]  regAddrT;
    // instruction fields
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;
    // alu operation select
    typedef logic [3:0]  aluCtrlT;

    // alu operation codes
    localparam aluCtrlT aluAnd = 4'd0;
    localparam aluCtrlT aluOr  = 4'd1;
    localparam aluCtrlT aluAdd = 4'd2;
    localparam aluCtrlT aluSub = 4'd6;
    localparam aluCtrlT aluSlt = 4'd7;
    localparam aluCtrlT aluNor = 4'd12;

    // supported opcodes
    localparam opcodeT opRFormat = 6'd0;
    localparam opcodeT opAddi    = 6'd8;

    // r-format funct values
    localparam functT fnAdd = 6'd32;
    localparam functT fnSub = 6'd34;
    localparam functT fnAnd = 6'd36;
    localparam functT fnOr  = 6'd37;
    localparam functT fnSlt = 6'd42;

    //////////////////////////////////////////////////////////////////////
    // pipeline records
    //////////////////////////////////////////////////////////////////////

    // decode stage output, forms the ID/EX register with the operands
    typedef struct packed {
        logic    valid;
        logic    regWrite;
        logic    useImmediate;
        aluCtrlT aluCtrl;
        regAddrT rs;
        regAddrT rt;
        regAddrT dest;
        wordT    immediate;
    } decodedOpT;

    // register file read results
    typedef struct packed {
        wordT dataA;
        wordT dataB;
    } operandsT;

    // result of the execute stage, also the register write request
    typedef struct packed {
        logic    valid;
        regAddrT dest;
        wordT    data;
    } writebackT;

endpackage

`default_nettype wire

//--- hdl/aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
    input  mipsPkg::aluCtrlT aluCtrl,
    input  mipsPkg::wordT    inA,
    input  mipsPkg::wordT    inB,
    output mipsPkg::wordT    out
);
    import mipsPkg::*;

    // unsigned compare, used by slt
    logic lessThan;

    assign lessThan = (inA < inB);

    always_comb begin
        case (aluCtrl)
            // bitwise and
            aluAnd: out = inA & inB;
            // bitwise or
            aluOr:  out = inA | inB;
            // add, wraps mod 2^32
            aluAdd: out = inA + inB;
            // subtract, wraps mod 2^32
            aluSub: out = inA - inB;
            // set on less than, 1 or 0
            aluSlt: out = {31'd0, lessThan};
            // bitwise nor
            aluNor: out = ~(inA | inB);
            // unused codes
            default: out = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input  logic               clock,
    input  logic               WriteEnable,
    input  mipsPkg::regAddrT   readAddrA,
    input  mipsPkg::regAddrT   readAddrB,
    output mipsPkg::operandsT  operands,
    input  mipsPkg::writebackT result
);
    import mipsPkg::*;

    // 32 general purpose words
    wordT regBank [32];

    // one read port
    // register 0 is hard zero, a pending write is passed straight through
    function automatic wordT readPort(regAddrT addr);
        wordT value;
        if (addr == '0) begin
            value = '0;
        end else if (result.valid && (result.dest == addr)) begin
            // write-through
            value = result.data;
        end else begin
            value = regBank[addr];
        end
        return value;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // combinational reads
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        operands.dataA = readPort(readAddrA);
        operands.dataB = readPort(readAddrB);
    end

    //////////////////////////////////////////////////////////////////////
    // write at the rising edge, whole bank cleared on reset
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge WriteEnable) begin
        if (WriteEnable) begin
            for (int i = 0; i < 32; i++) begin
                regBank[i] <= '0;
            end
        end else if (result.valid && (result.dest != '0)) begin
            // writes to register 0 are dropped
            regBank[result.dest] <= result.data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/instructionDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instructionDecoder (
    input  logic               clock,
    input  logic               WriteEnable,
    input  mipsPkg::wordT      instruction,
    input  logic               instrValid,
    input  mipsPkg::operandsT  operands,
    output mipsPkg::decodedOpT decoded,
    output mipsPkg::operandsT  decodedOperands
);
    import mipsPkg::*;

    // instruction fields
    opcodeT    opcode;
    functT     funct;
    // known encoding
    logic      supported;
    decodedOpT decodeNext;

    assign opcode = instruction[31:26];
    assign funct  = instruction[5:0];

    //////////////////////////////////////////////////////////////////////
    // opcode and funct lookup
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        supported               = 1'b0;
        decodeNext.useImmediate = 1'b0;
        decodeNext.aluCtrl      = aluAdd;
        decodeNext.rs           = instruction[25:21];
        decodeNext.rt           = instruction[20:16];
        // rd by default
        decodeNext.dest         = instruction[15:11];
        // sign extend the low half
        decodeNext.immediate    = {{16{instruction[15]}}, instruction[15:0]};

        case (opcode)
            opRFormat: begin
                // alu op comes from funct
                supported = 1'b1;
                case (funct)
                    fnAdd:   decodeNext.aluCtrl = aluAdd;
                    fnSub:   decodeNext.aluCtrl = aluSub;
                    fnAnd:   decodeNext.aluCtrl = aluAnd;
                    fnOr:    decodeNext.aluCtrl = aluOr;
                    fnSlt:   decodeNext.aluCtrl = aluSlt;
                    default: supported = 1'b0;
                endcase
            end
            opAddi: begin
                // add with immediate, result goes to rt
                supported               = 1'b1;
                decodeNext.useImmediate = 1'b1;
                decodeNext.aluCtrl      = aluAdd;
                decodeNext.dest         = instruction[20:16];
            end
            default: begin
                supported = 1'b0;
            end
        endcase

        // unknown encodings and idle cycles become bubbles
        decodeNext.valid    = instrValid && supported;
        decodeNext.regWrite = supported;
    end

    //////////////////////////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////////////////////////

    // control part
    always_ff @(posedge clock or posedge WriteEnable) begin
        if (WriteEnable) begin
            decoded <= '0;
        end else begin
            decoded <= decodeNext;
        end
    end

    // operand pair, captured on the same edge
    always_ff @(posedge clock) begin
        decodedOperands <= operands;
    end

endmodule

`default_nettype wire

//--- hdl/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  logic               clock,
    input  logic               WriteEnable,
    input  mipsPkg::decodedOpT decoded,
    input  mipsPkg::operandsT  decodedOperands,
    output mipsPkg::writebackT result
);
    import mipsPkg::*;

    // EX/WB register fields
    logic    resultValid;
    regAddrT resultDest;
    wordT    resultData;

    // forwarding selects
    logic    forwardA;
    logic    forwardB;

    // operand muxing
    wordT    operandA;
    wordT    operandB;
    wordT    aluB;
    wordT    aluOut;

    //////////////////////////////////////////////////////////////////////
    // forwarding from the held result
    //////////////////////////////////////////////////////////////////////

    // held result must be a real write to a nonzero register
    assign forwardA = resultValid && (resultDest != '0) && (resultDest == decoded.rs);
    assign forwardB = resultValid && (resultDest != '0) && (resultDest == decoded.rt);

    // older dependencies already resolved in the register file
    assign operandA = forwardA ? resultData : decodedOperands.dataA;
    assign operandB = forwardB ? resultData : decodedOperands.dataB;

    // addi takes the sign-extended immediate on B
    assign aluB = decoded.useImmediate ? decoded.immediate : operandB;

    //////////////////////////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////////////////////////

    aluUnit alu (
        .aluCtrl (decoded.aluCtrl),
        .inA     (operandA),
        .inB     (aluB),
        .out     (aluOut)
    );

    //////////////////////////////////////////////////////////////////////
    // EX/WB register
    //////////////////////////////////////////////////////////////////////

    // valid only for instructions that write
    always_ff @(posedge clock or posedge WriteEnable) begin
        if (WriteEnable) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= decoded.valid && decoded.regWrite;
        end
    end

    // payload, qualified by resultValid
    always_ff @(posedge clock) begin
        resultDest <= decoded.dest;
        resultData <= aluOut;
    end

    // drives wb and the register write port
    assign result.valid = resultValid;
    assign result.dest  = resultDest;
    assign result.data  = resultData;

endmodule

`default_nettype wire

//--- hdl/aluPipeline.sv
`timescale 1ns/1ns
`default_nettype none

module aluPipeline (
    input  logic               clock,
    input  logic               WriteEnable,
    input  mipsPkg::wordT      instruction,
    input  logic               instrValid,
    output mipsPkg::writebackT wb
);
    import mipsPkg::*;

    // register reads for the incoming instruction
    operandsT  operands;
    // ID/EX register contents
    decodedOpT decoded;
    operandsT  decodedOperands;

    //////////////////////////////////////////////////////////////////////
    // decode, side by side with the register read
    //////////////////////////////////////////////////////////////////////

    instructionDecoder decoder (
        .clock           (clock),
        .WriteEnable     (WriteEnable),
        .instruction     (instruction),
        .instrValid      (instrValid),
        .operands        (operands),
        .decoded         (decoded),
        .decodedOperands (decodedOperands)
    );

    // rs and rt fields address the two read ports
    // wb doubles as the write request
    registerFile regFile (
        .clock       (clock),
        .WriteEnable (WriteEnable),
        .readAddrA   (instruction[25:21]),
        .readAddrB   (instruction[20:16]),
        .operands    (operands),
        .result      (wb)
    );

    //////////////////////////////////////////////////////////////////////
    // execute and result register
    //////////////////////////////////////////////////////////////////////

    executeStage execute (
        .clock           (clock),
        .WriteEnable     (WriteEnable),
        .decoded         (decoded),
        .decodedOperands (decodedOperands),
        .result          (wb)
    );

endmodule

`default_nettype wire

//--- verification/pipelineVectors.svh
// addRow columns are instruction, expected wb dest, expected wb data and test number
// addRejected and addBubble rows expect wb.valid low
`ifndef PIPELINE_VECTORS_SVH
`define PIPELINE_VECTORS_SVH

task automatic loadVectors();
    //////////////////////////////////////////////////////////////////////
    // cleared registers, constant loads
    //////////////////////////////////////////////////////////////////////
    addRow(encodeRFormat(fnAdd, 5'd3, 5'd1, 5'd2), 5'd3, 32'h0000_0000, 1);
    addRow(encodeImmediate(opAddi, 5'd1, 5'd0, 16'h0064), 5'd1, 32'h0000_0064, 1);
    // negative constants sign extend
    addRow(encodeImmediate(opAddi, 5'd2, 5'd0, 16'hfffb), 5'd2, 32'hffff_fffb, 1);
    addRow(encodeImmediate(opAddi, 5'd4, 5'd0, 16'h7fff), 5'd4, 32'h0000_7fff, 1);
    addRow(encodeImmediate(opAddi, 5'd5, 5'd0, 16'h8000), 5'd5, 32'hffff_8000, 1);

    // each r-format op on loaded registers
    addRow(encodeRFormat(fnAdd, 5'd6, 5'd1, 5'd2), 5'd6, 32'h0000_005f, 2);
    // 100 minus 32767 wraps
    addRow(encodeRFormat(fnSub, 5'd7, 5'd1, 5'd4), 5'd7, 32'hffff_8065, 2);
    addRow(encodeRFormat(fnAnd, 5'd8, 5'd2, 5'd4), 5'd8, 32'h0000_7ffb, 2);
    addRow(encodeRFormat(fnOr, 5'd9, 5'd1, 5'd5), 5'd9, 32'hffff_8064, 2);
    // unsigned compare puts 100 below 0xfffffffb
    addRow(encodeRFormat(fnSlt, 5'd10, 5'd1, 5'd2), 5'd10, 32'h0000_0001, 2);
    addRow(encodeRFormat(fnSlt, 5'd11, 5'd2, 5'd1), 5'd11, 32'h0000_0000, 2);

    //////////////////////////////////////////////////////////////////////
    // dependencies
    //////////////////////////////////////////////////////////////////////
    // back to back through the execute result
    addRow(encodeImmediate(opAddi, 5'd12, 5'd0, 16'h0007), 5'd12, 32'h0000_0007, 3);
    addRow(encodeRFormat(fnAdd, 5'd13, 5'd12, 5'd12), 5'd13, 32'h0000_000e, 3);
    addRow(encodeRFormat(fnSub, 5'd14, 5'd13, 5'd1), 5'd14, 32'hffff_ffaa, 3);
    addRow(encodeRFormat(fnOr, 5'd15, 5'd1, 5'd14), 5'd15, 32'hffff_ffee, 3);

    // two apart via write-through and three apart via plain read
    addRow(encodeImmediate(opAddi, 5'd16, 5'd0, 16'h0123), 5'd16, 32'h0000_0123, 4);
    addBubble(4);
    addRow(encodeRFormat(fnAdd, 5'd17, 5'd16, 5'd1), 5'd17, 32'h0000_0187, 4);
    addBubble(4);
    addBubble(4);
    addRow(encodeRFormat(fnSub, 5'd18, 5'd17, 5'd16), 5'd18, 32'h0000_0064, 4);
    addRow(encodeImmediate(opAddi, 5'd19, 5'd0, 16'h0003), 5'd19, 32'h0000_0003, 4);
    addRow(encodeImmediate(opAddi, 5'd20, 5'd0, 16'h0004), 5'd20, 32'h0000_0004, 4);
    addRow(encodeRFormat(fnAdd, 5'd21, 5'd19, 5'd20), 5'd21, 32'h0000_0007, 4);

    //////////////////////////////////////////////////////////////////////
    // register 0 and bubbles
    //////////////////////////////////////////////////////////////////////
    // shown on wb but never stored
    addRow(encodeImmediate(opAddi, 5'd0, 5'd0, 16'h0037), 5'd0, 32'h0000_0037, 5);
    addRow(encodeRFormat(fnAdd, 5'd27, 5'd0, 5'd0), 5'd27, 32'h0000_0000, 5);
    addRow(encodeRFormat(fnOr, 5'd28, 5'd0, 5'd1), 5'd28, 32'h0000_0064, 5);
    addBubble(5);
    // jump, load word, shift and nor are not decoded
    addRejected(encodeImmediate(6'd2, 5'd9, 5'd1, 16'h0010), 5);
    // load offset whose rd bits also name r29
    addRejected(encodeImmediate(6'd35, 5'd29, 5'd1, 16'he804), 5);
    addRejected(encodeRFormat(6'd0, 5'd29, 5'd1, 5'd2), 5);
    addRejected(encodeRFormat(6'd39, 5'd29, 5'd1, 5'd2), 5);
    // r29 untouched by the rejected ops one, two and three rows back
    addRow(encodeRFormat(fnAdd, 5'd30, 5'd29, 5'd0), 5'd30, 32'h0000_0000, 5);

    // six in flight with each one leaning on the last
    addRow(encodeImmediate(opAddi, 5'd1, 5'd1, 16'h0001), 5'd1, 32'h0000_0065, 6);
    addRow(encodeRFormat(fnAdd, 5'd2, 5'd1, 5'd1), 5'd2, 32'h0000_00ca, 6);
    addRow(encodeRFormat(fnSub, 5'd3, 5'd2, 5'd1), 5'd3, 32'h0000_0065, 6);
    addRow(encodeRFormat(fnAnd, 5'd4, 5'd3, 5'd2), 5'd4, 32'h0000_0040, 6);
    addRow(encodeRFormat(fnOr, 5'd5, 5'd4, 5'd1), 5'd5, 32'h0000_0065, 6);
    addRow(encodeRFormat(fnSlt, 5'd6, 5'd5, 5'd2), 5'd6, 32'h0000_0001, 6);
endtask

`endif

//--- verification/aluPipelineTb.sv
`timescale 1ns/1ns
`default_nettype none

module aluPipelineTb;
    import mipsPkg::*;

    // one stimulus row with its expected writeback
    typedef struct packed {
        wordT    instruction;
        logic    instrValid;
        logic    expValid;
        regAddrT expDest;
        wordT    expData;
        int      testNum;
    } vectorRowT;

    // cycles allowed for reset release
    localparam int resetTimeout = 20;

    // dut signals
    logic      clock = 1'b0;
    logic      WriteEnable;
    wordT      instruction;
    logic      instrValid;
    writebackT wb;

    // stimulus table filled by loadVectors
    vectorRowT   vectorTable [$];
    // overall tallies
    int          checkCount;
    int          errorCount;
    // tallies of the test in progress
    int          testRows;
    int          testErrors;
    int          waitCycles;
    int unsigned seedValue;

    aluPipeline uut (
        .clock       (clock),
        .WriteEnable (WriteEnable),
        .instruction (instruction),
        .instrValid  (instrValid),
        .wb          (wb)
    );

    // 10 ns period
    always #5 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // instruction encoding and table rows
    //////////////////////////////////////////////////////////////////////

    // op rd, rs, rt
    function automatic wordT encodeRFormat(functT funct, regAddrT rd, regAddrT rs, regAddrT rt);
        return {opRFormat, rs, rt, rd, 5'd0, funct};
    endfunction

    // op rt, rs, imm
    function automatic wordT encodeImmediate(opcodeT opcode, regAddrT rt, regAddrT rs,
                                             logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    // valid instruction with a result
    task automatic addRow(input wordT instr, input regAddrT dest, input wordT data,
                          input int testNum);
        vectorRowT row;
        row = '{instr, 1'b1, 1'b1, dest, data, testNum};
        vectorTable.push_back(row);
    endtask

    // valid but unsupported encoding with no result
    task automatic addRejected(input wordT instr, input int testNum);
        vectorRowT row;
        row = '{instr, 1'b1, 1'b0, 5'd0, 32'h0, testNum};
        vectorTable.push_back(row);
    endtask

    // idle cycle with instruction bits filled at drive time
    task automatic addBubble(input int testNum);
        vectorRowT row;
        row = '{32'h0, 1'b0, 1'b0, 5'd0, 32'h0, testNum};
        vectorTable.push_back(row);
    endtask

    `include "pipelineVectors.svh"

    //////////////////////////////////////////////////////////////////////
    // drive and check
    //////////////////////////////////////////////////////////////////////

    task automatic driveRow(input vectorRowT row);
        if (row.instrValid) begin
            instruction <= row.instruction;
        end else begin
            // legal addi with random fields that only instrValid holds back
            instruction <= {opAddi, 26'($urandom)};
        end
        instrValid <= row.instrValid;
    endtask

    // compare wb with the row issued two edges earlier
    task automatic checkRow(input int index);
        vectorRowT row;
        logic      rowFailed;
        row       = vectorTable[index];
        rowFailed = 1'b0;
        checkCount++;
        testRows++;
        if (wb.valid !== row.expValid) begin
            $display("error at %0t ns: row %0d wb.valid is %b, expected %b",
                     $time, index, wb.valid, row.expValid);
            rowFailed = 1'b1;
        end else if (row.expValid) begin
            if (wb.dest !== row.expDest) begin
                $display("error at %0t ns: row %0d wb.dest is %0d, expected %0d",
                         $time, index, wb.dest, row.expDest);
                rowFailed = 1'b1;
            end
            if (wb.data !== row.expData) begin
                $display("error at %0t ns: row %0d wb.data is %h, expected %h",
                         $time, index, wb.data, row.expData);
                rowFailed = 1'b1;
            end
        end
        if (rowFailed) begin
            errorCount++;
            testErrors++;
        end
        // last row of this test
        if (index == vectorTable.size() - 1) begin
            reportTest(row.testNum);
        end else if (vectorTable[index + 1].testNum != row.testNum) begin
            reportTest(row.testNum);
        end
    endtask

    task automatic reportTest(input int testNum);
        if (testErrors == 0) begin
            $display("test %0d passed, %0d rows", testNum, testRows);
        end else begin
            $display("test %0d failed, %0d of %0d rows wrong", testNum, testErrors, testRows);
        end
        testRows   = 0;
        testErrors = 0;
    endtask

    // two extra cycles drain the pipeline
    task automatic runVectors();
        int rowCount;
        rowCount = vectorTable.size();
        for (int cycle = 0; cycle < rowCount + 2; cycle++) begin
            @(posedge clock);
            if (cycle < rowCount) begin
                driveRow(vectorTable[cycle]);
            end else begin
                instrValid  <= 1'b0;
                instruction <= $urandom;
            end
            // wb settled mid cycle
            @(negedge clock);
            if (cycle >= 2) begin
                checkRow(cycle - 2);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reset and main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        WriteEnable = 1'b1;
        repeat (4) @(posedge clock);
        WriteEnable <= 1'b0;
    end

    initial begin
        instruction = '0;
        instrValid  = 1'b0;
        checkCount  = 0;
        errorCount  = 0;
        testRows    = 0;
        testErrors  = 0;
        seedValue   = $urandom(32'hfed4);
        loadVectors();

        // wait for reset release
        waitCycles = 0;
        while ((WriteEnable !== 1'b0) && (waitCycles < resetTimeout)) begin
            @(posedge clock);
            waitCycles++;
        end

        if (WriteEnable !== 1'b0) begin
            $display("reset was still active after %0d cycles, run stopped", waitCycles);
            $display("Testbench failed");
            $finish;
        end else begin
            runVectors();
            $display("%0d rows checked, %0d errors", checkCount, errorCount);
            if (errorCount == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+verification
hdl/mipsPkg.sv
hdl/aluUnit.sv
hdl/registerFile.sv
hdl/instructionDecoder.sv
hdl/executeStage.sv
hdl/aluPipeline.sv
verification/aluPipelineTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module aluPipelineTb \
    -f build.f -o aluPipelineSim || exit 1

simOutput="$(./obj_dir/aluPipelineSim)"
printf '%s\n' "$simOutput"

# pass only when the testbench printed its pass line
printf '%s\n' "$simOutput" | grep -qx "Testbench passed" && exit 0 || exit 1
